// File: cache_pkg.sv
package cache_pkg;

   // Address split, tag | index | byte offset
   localparam int tag_w = 5;
   localparam int index_w = 8;
   localparam int offset_w = 3;

   // Line geometry
   localparam int word_w = 16;
   localparam int words_per_line = 4;
   localparam int num_sets = 1 << index_w;
   localparam int word_sel_w = $clog2(words_per_line);

   typedef logic [tag_w-1:0]    tag_t;
   typedef logic [index_w-1:0]  index_t;
   typedef logic [offset_w-1:0] offset_t;
   typedef logic [word_w-1:0]   word_t;

   // Writeback and fill states use consecutive codes
   typedef enum logic [3:0] {
      st_idle,
      st_compare,
      st_check,
      st_wb0, st_wb1, st_wb2, st_wb3,
      st_fill_issue,
      st_fill_wr0, st_fill_wr1, st_fill_wr2, st_fill_wr3,
      st_final_cmp,
      st_finish
   } ctrl_state_t;

endpackage

// File: mem_pkg.sv
package mem_pkg;

   // Main memory, word interleaved over the banks
   localparam int mem_words = 32768;
   localparam int num_banks = 4;
   localparam int bank_words = mem_words / num_banks;

   // Bank select sits just above the byte bit
   localparam int bank_w = $clog2(num_banks);
   localparam int row_w = $clog2(bank_words);

   // Cycles from rd strobe to data
   localparam int rd_latency = 2;

endpackage

// File: cache_way_if.sv
`timescale 1ns/1ps

interface cache_way_if;
   import cache_pkg::*;

   // Controller to way
   logic    enable;
   logic    comp;
   logic    write;
   tag_t    tag_in;
   index_t  index;
   offset_t offset;
   word_t   data_in;

   // Way to controller, registered
   word_t   data_out;
   tag_t    tag_out;
   logic    hit;
   logic    valid;
   logic    dirty;

   modport ctrl (
      output enable, comp, write, tag_in, index, offset, data_in,
      input  data_out, tag_out, hit, valid, dirty
   );

   modport way (
      input  enable, comp, write, tag_in, index, offset, data_in,
      output data_out, tag_out, hit, valid, dirty
   );

endinterface

// File: cache_way.sv
`timescale 1ns/1ps

module cache_way (
   input  logic     clk,
   input  logic     arst_n,
   cache_way_if.way bus
);
   import cache_pkg::*;

   word_t               data_arr [num_sets * words_per_line];
   tag_t                tag_arr [num_sets];
   logic [num_sets-1:0] valid_arr;
   logic [num_sets-1:0] dirty_arr;

   logic [index_w+word_sel_w-1:0] word_addr;
   logic                          tag_match;
   logic                          wr_access;
   logic                          wr_hit;

   // Word within the line comes from the offset above the byte bit
   assign word_addr = {bus.index, bus.offset[offset_w-1 -: word_sel_w]};

   assign tag_match = valid_arr[bus.index] & (tag_arr[bus.index] == bus.tag_in);

   // Access mode write loads a fresh clean line word
   assign wr_access = bus.enable & bus.write & ~bus.comp;

   // Compare mode write only lands on a hit
   assign wr_hit = bus.enable & bus.write & bus.comp & tag_match;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_arr <= '0;
         bus.hit   <= 1'b0;
         bus.valid <= 1'b0;
         bus.dirty <= 1'b0;
      end else if (bus.enable) begin
         bus.hit   <= bus.comp & tag_match;
         bus.valid <= valid_arr[bus.index];
         // Dirty only means something on a valid line
         bus.dirty <= valid_arr[bus.index] & dirty_arr[bus.index];
         if (wr_access) begin
            valid_arr[bus.index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bus.enable) begin
         bus.data_out <= data_arr[word_addr];
         bus.tag_out  <= tag_arr[bus.index];
      end
      if (wr_access || wr_hit) begin
         data_arr[word_addr] <= bus.data_in;
      end
      if (wr_access) begin
         tag_arr[bus.index]   <= bus.tag_in;
         dirty_arr[bus.index] <= 1'b0;
      end else if (wr_hit) begin
         dirty_arr[bus.index] <= 1'b1;
      end
   end

endmodule

// File: four_bank_mem.sv
`timescale 1ns/1ps

module four_bank_mem (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rd,
   input  logic             wr,
   input  logic [15:0]      addr,
   input  cache_pkg::word_t data_in,
   output cache_pkg::word_t data_out
);
   import cache_pkg::*;
   import mem_pkg::*;

   logic [bank_w-1:0] bank_sel;
   logic [row_w-1:0]  row;
   logic [bank_w-1:0] sel_q;
   logic              rd_vld_q;
   word_t             bank_rd [num_banks];

   // Bits 2:1 pick the bank, the rest the row inside it
   assign bank_sel = addr[bank_w:1];
   assign row = addr[15:bank_w+1];

   for (genvar b = 0; b < num_banks; b++) begin : g_bank
      word_t arr [bank_words];
      word_t rd_q;

      initial begin
         for (int i = 0; i < bank_words; i++) begin
            arr[i] = '0;
         end
      end

      // First stage, bank array read
      always_ff @(posedge clk) begin
         if (wr && bank_sel == bank_w'(b)) begin
            arr[row] <= data_in;
         end
         if (rd && bank_sel == bank_w'(b)) begin
            rd_q <= arr[row];
         end
      end

      assign bank_rd[b] = rd_q;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_vld_q <= 1'b0;
      end else begin
         rd_vld_q <= rd;
      end
   end

   // Second stage, steer the read bank to the output
   always_ff @(posedge clk) begin
      if (rd) begin
         sel_q <= bank_sel;
      end
      if (rd_vld_q) begin
         data_out <= bank_rd[sel_q];
      end
   end

endmodule

// File: mem_system.sv
`timescale 1ns/1ps

module mem_system (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [15:0] addr,
   input  logic [15:0] data_in,
   input  logic        rd,
   input  logic        wr,
   output logic [15:0] data_out,
   output logic        done,
   output logic        stall,
   output logic        cache_hit,
   output logic        err
);
   import cache_pkg::*;
   import mem_pkg::*;

   cache_way_if way0_bus ();
   cache_way_if way1_bus ();

   ctrl_state_t state;
   ctrl_state_t next_state;

   // Held request
   logic [15:0] req_addr;
   word_t       req_data;
   logic        req_wr;
   logic        req_err;
   tag_t        req_tag;
   index_t      req_index;

   // Replacement and victim
   logic repl;
   logic victim;
   logic victim_c;
   logic victim_dirty;
   tag_t victim_tag;
   word_t victim_data;

   // Way control, shared by both ways except the enables
   logic    en0;
   logic    en1;
   logic    way_comp;
   logic    way_write;
   offset_t way_offset;
   word_t   way_data;

   // Memory port
   logic        mem_rd;
   logic        mem_wr;
   logic [15:0] mem_addr;
   word_t       mem_rdata;

   logic                  hit_any;
   logic                  illegal;
   logic                  accept;
   logic [word_sel_w-1:0] issue_cnt;
   logic [word_sel_w-1:0] step_word;

   // Line word handled by a writeback or fill state
   function automatic logic [word_sel_w-1:0] state_word(input ctrl_state_t s);
      case (s)
         st_wb1, st_fill_wr1: state_word = word_sel_w'(1);
         st_wb2, st_fill_wr2: state_word = word_sel_w'(2);
         st_wb3, st_fill_wr3: state_word = word_sel_w'(3);
         default:             state_word = '0;
      endcase
   endfunction

   cache_way way0 (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (way0_bus)
   );

   cache_way way1 (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (way1_bus)
   );

   four_bank_mem mem0 (
      .clk      (clk),
      .arst_n   (arst_n),
      .rd       (mem_rd),
      .wr       (mem_wr),
      .addr     (mem_addr),
      .data_in  (victim_data),
      .data_out (mem_rdata)
   );

   assign req_tag = req_addr[15 -: tag_w];
   assign req_index = req_addr[offset_w +: index_w];
   assign step_word = state_word(state);

   assign way0_bus.enable  = en0;
   assign way0_bus.comp    = way_comp;
   assign way0_bus.write   = way_write;
   assign way0_bus.tag_in  = req_tag;
   assign way0_bus.index   = req_index;
   assign way0_bus.offset  = way_offset;
   assign way0_bus.data_in = way_data;

   assign way1_bus.enable  = en1;
   assign way1_bus.comp    = way_comp;
   assign way1_bus.write   = way_write;
   assign way1_bus.tag_in  = req_tag;
   assign way1_bus.index   = req_index;
   assign way1_bus.offset  = way_offset;
   assign way1_bus.data_in = way_data;

   assign hit_any = way0_bus.hit | way1_bus.hit;
   assign illegal = (rd & wr) | addr[0];

   assign done = ((state == st_check) & hit_any) | (state == st_finish);
   assign err = (state == st_finish) & req_err;
   assign cache_hit = (state == st_check) & hit_any;
   assign stall = (rd | wr) & ~done;

   // Take a new request when idle or in the done cycle
   assign accept = (rd | wr) & ((state == st_idle) | done);

   assign data_out = way1_bus.hit ? way1_bus.data_out : way0_bus.data_out;
   assign victim_data = victim ? way1_bus.data_out : way0_bus.data_out;

   // Invalid way first, way 0 before way 1, then the replacement bit
   always_comb begin
      if (!way0_bus.valid) begin
         victim_c = 1'b0;
      end else if (!way1_bus.valid) begin
         victim_c = 1'b1;
      end else begin
         victim_c = repl;
      end
   end

   assign victim_dirty = victim_c ? way1_bus.dirty : way0_bus.dirty;

   always_comb begin
      next_state = state;
      en0 = 1'b0;
      en1 = 1'b0;
      way_comp = 1'b0;
      way_write = 1'b0;
      way_offset = req_addr[offset_w-1:0];
      way_data = req_data;
      mem_rd = 1'b0;
      mem_wr = 1'b0;
      mem_addr = {req_tag, req_index, issue_cnt, 1'b0};

      case (state)
         st_idle: begin
            next_state = st_idle;
         end
         st_compare, st_final_cmp: begin
            en0 = 1'b1;
            en1 = 1'b1;
            way_comp = 1'b1;
            way_write = req_wr;
            next_state = (state == st_compare) ? st_check : st_finish;
         end
         st_check: begin
            if (hit_any) begin
               next_state = st_idle;
            end else if (victim_dirty) begin
               // Start reading the victim line at word 0
               en0 = ~victim_c;
               en1 = victim_c;
               way_offset = '0;
               next_state = st_wb0;
            end else begin
               next_state = st_fill_issue;
            end
         end
         st_wb0, st_wb1, st_wb2, st_wb3: begin
            mem_wr = 1'b1;
            mem_addr = {victim_tag, req_index, step_word, 1'b0};
            if (state != st_wb3) begin
               // Next victim word arrives for the following state
               en0 = ~victim;
               en1 = victim;
               way_offset = {step_word + 1'b1, 1'b0};
               next_state = ctrl_state_t'(state + 1'b1);
            end else begin
               next_state = st_fill_issue;
            end
         end
         st_fill_issue: begin
            mem_rd = 1'b1;
            if (issue_cnt == word_sel_w'(rd_latency - 1)) begin
               next_state = st_fill_wr0;
            end
         end
         st_fill_wr0, st_fill_wr1, st_fill_wr2, st_fill_wr3: begin
            // Remaining reads overlap with the first returns
            mem_rd = (issue_cnt != '0);
            en0 = ~victim;
            en1 = victim;
            way_write = 1'b1;
            way_offset = {step_word, 1'b0};
            way_data = mem_rdata;
            if (state == st_fill_wr3) begin
               next_state = st_final_cmp;
            end else begin
               next_state = ctrl_state_t'(state + 1'b1);
            end
         end
         st_finish: begin
            next_state = st_idle;
         end
         default: begin
            next_state = st_idle;
         end
      endcase

      if (accept) begin
         next_state = illegal ? st_finish : st_compare;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
         req_wr <= 1'b0;
         req_err <= 1'b0;
         repl <= 1'b0;
         victim <= 1'b0;
         issue_cnt <= '0;
      end else begin
         state <= next_state;
         if (accept) begin
            req_wr <= wr;
            req_err <= illegal;
         end
         // Flips on every completed access
         if (done && !err) begin
            repl <= ~repl;
         end
         if (state == st_check) begin
            victim <= victim_c;
         end
         issue_cnt <= mem_rd ? issue_cnt + 1'b1 : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
      end
      if (state == st_check) begin
         victim_tag <= victim_c ? way1_bus.tag_out : way0_bus.tag_out;
      end
   end

endmodule

// File: tb_mem_system.sv
`timescale 1ns/1ps

module tb_mem_system;

   localparam int num_random = 250;
   localparam int num_directed = 20;
   // Up to two passes per request with a dirty miss of about 16 cycles as the worst
   localparam int timeout_cycles = (num_random + num_directed) * 2 * 24 + 16;

   logic        clk;
   logic        arst_n;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // Reference model, logical memory plus resident tags per set
   logic [15:0] ref_mem [32768];
   logic [4:0]  res_tag [256][2];
   logic        res_valid [256][2];
   logic        ref_repl;

   logic        exp_hit;
   logic        exp_err;
   logic        exp_read;
   logic [15:0] exp_data;

   int cycles;
   int seed;

   mem_system dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1);
   endtask

   function automatic logic [15:0] make_addr(input logic [4:0] tg, input logic [7:0] ix,
                                             input logic [1:0] wd);
      make_addr = {tg, ix, wd, 1'b0};
   endfunction

   // One access as the cache should see it
   task automatic model_access(input logic r, input logic w, input logic [15:0] a,
                               input logic [15:0] d);
      logic [4:0] tg;
      logic [7:0] ix;
      int         way;
      tg = a[15:11];
      ix = a[10:3];
      exp_err = (r && w) || a[0];
      exp_read = r && !exp_err;
      exp_hit = 1'b0;
      if (!exp_err) begin
         if (res_valid[ix][0] && res_tag[ix][0] == tg) begin
            exp_hit = 1'b1;
         end else if (res_valid[ix][1] && res_tag[ix][1] == tg) begin
            exp_hit = 1'b1;
         end else begin
            // Invalid way first, then the replacement bit
            if (!res_valid[ix][0]) begin
               way = 0;
            end else if (!res_valid[ix][1]) begin
               way = 1;
            end else begin
               way = ref_repl ? 1 : 0;
            end
            res_valid[ix][way] = 1'b1;
            res_tag[ix][way] = tg;
         end
         if (w) begin
            ref_mem[a[15:1]] = d;
         end
         exp_data = ref_mem[a[15:1]];
         ref_repl = ~ref_repl;
      end
   endtask

   // Strobes drop at the edge drop_at cycles in, none when drop_at is 0
   task automatic wait_done(input int drop_at, output int lat);
      logic seen;
      lat = 0;
      seen = 1'b0;
      while (!seen) begin
         if (lat > 0) begin
            @(posedge clk);
         end
         if (lat + 1 == drop_at) begin
            rd <= 1'b0;
            wr <= 1'b0;
         end
         @(negedge clk);
         lat = lat + 1;
         seen = done;
         if (lat > 40) begin
            report_fail("No done pulse for a held request");
         end
      end
   endtask

   task automatic check_done(input int lat);
      assert (err === exp_err) else
         report_fail($sformatf("ERR %0t err expected %b got %b", $time, exp_err, err));
      assert (cache_hit === exp_hit) else
         report_fail($sformatf("ERR %0t cache_hit expected %b got %b",
                               $time, exp_hit, cache_hit));
      assert (!exp_read || data_out === exp_data) else
         report_fail($sformatf("ERR %0t data_out expected %h got %h",
                               $time, exp_data, data_out));
      assert (!exp_hit || lat == 2) else
         report_fail($sformatf("ERR %0t hit latency expected 2 got %0d", $time, lat));
      assert (!exp_err || lat == 1) else
         report_fail($sformatf("ERR %0t err latency expected 1 got %0d", $time, lat));
   endtask

   // A held request is taken a second time in its done cycle
   task automatic run_access(input logic r, input logic w, input logic [15:0] a,
                             input logic [15:0] d, input logic held);
      int lat;
      int drop_at;
      model_access(r, w, a, d);
      // Hits and errors end at a known cycle and let the strobes drop in time
      if (held) begin
         drop_at = 0;
      end else if (exp_err) begin
         drop_at = 1;
      end else if (exp_hit) begin
         drop_at = 2;
      end else begin
         drop_at = 0;
      end
      @(posedge clk);
      rd <= r;
      wr <= w;
      addr <= a;
      data_in <= d;
      @(posedge clk);
      wait_done(drop_at, lat);
      check_done(lat);
      @(posedge clk);
      if (drop_at == 0) begin
         rd <= 1'b0;
         wr <= 1'b0;
         model_access(r, w, a, d);
         wait_done(0, lat);
         check_done(lat);
         @(posedge clk);
      end
   endtask

   always @(negedge clk) begin
      if (arst_n) begin
         assert (stall === ((rd | wr) & ~done)) else
            report_fail($sformatf("ERR %0t stall expected %b got %b",
                                  $time, (rd | wr) & ~done, stall));
         assert (done || (!cache_hit && !err)) else
            report_fail("cache_hit or err pulsed without done");
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= timeout_cycles) begin
         report_fail("Simulation timed out before all tests finished");
      end
   end

   initial begin
      logic [7:0]  ix_list [4];
      logic [4:0]  tag_list [6];
      logic [15:0] a;
      logic        hold;
      int          k;
      cycles = 0;
      seed = 32'hfa0a_c4e4;
      ref_repl = 1'b0;
      for (int i = 0; i < 32768; i++) begin
         ref_mem[i] = '0;
      end
      for (int i = 0; i < 256; i++) begin
         res_valid[i][0] = 1'b0;
         res_valid[i][1] = 1'b0;
         res_tag[i][0] = '0;
         res_tag[i][1] = '0;
      end
      arst_n <= 1'b0;
      rd <= 1'b0;
      wr <= 1'b0;
      addr <= '0;
      data_in <= '0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;

      // Cold miss, then a hit on the same line
      run_access(1'b1, 1'b0, make_addr(5'd0, 8'h20, 2'd0), 16'h0, 1'b1);
      run_access(1'b1, 1'b0, make_addr(5'd0, 8'h20, 2'd0), 16'h0, 1'b1);
      // Write hit and read back
      run_access(1'b0, 1'b1, make_addr(5'd0, 8'h20, 2'd1), 16'hbeef, 1'b1);
      run_access(1'b1, 1'b0, make_addr(5'd0, 8'h20, 2'd1), 16'h0, 1'b1);
      // Crowd the set until the dirty line goes out
      run_access(1'b0, 1'b1, make_addr(5'd1, 8'h20, 2'd0), 16'h1111, 1'b1);
      run_access(1'b0, 1'b1, make_addr(5'd2, 8'h20, 2'd0), 16'h2222, 1'b1);
      run_access(1'b0, 1'b1, make_addr(5'd3, 8'h20, 2'd3), 16'h3333, 1'b1);
      run_access(1'b1, 1'b0, make_addr(5'd0, 8'h20, 2'd1), 16'h0, 1'b1);
      run_access(1'b1, 1'b0, make_addr(5'd1, 8'h20, 2'd0), 16'h0, 1'b1);
      // Victim order on a fresh set
      run_access(1'b1, 1'b0, make_addr(5'd4, 8'h40, 2'd0), 16'h0, 1'b1);
      run_access(1'b1, 1'b0, make_addr(5'd5, 8'h40, 2'd2), 16'h0, 1'b1);
      // A single done leaves the replacement bit set for the next miss
      run_access(1'b1, 1'b0, make_addr(5'd4, 8'h40, 2'd1), 16'h0, 1'b0);
      run_access(1'b1, 1'b0, make_addr(5'd6, 8'h40, 2'd0), 16'h0, 1'b1);
      run_access(1'b1, 1'b0, make_addr(5'd5, 8'h40, 2'd0), 16'h0, 1'b1);
      run_access(1'b1, 1'b0, make_addr(5'd4, 8'h40, 2'd3), 16'h0, 1'b1);
      // Illegal requests leave everything alone
      run_access(1'b1, 1'b1, make_addr(5'd0, 8'h20, 2'd1), 16'h5555, 1'b1);
      run_access(1'b0, 1'b1, make_addr(5'd0, 8'h20, 2'd1) | 16'h1, 16'h6666, 1'b0);
      run_access(1'b1, 1'b0, make_addr(5'd0, 8'h20, 2'd1), 16'h0, 1'b1);

      ix_list = '{8'h20, 8'h21, 8'h55, 8'haa};
      tag_list = '{5'd0, 5'd1, 5'd2, 5'd9, 5'd17, 5'd31};
      for (int n = 0; n < num_random; n++) begin
         k = {$random(seed)} % 6;
         a = make_addr(tag_list[k], ix_list[{$random(seed)} % 4], 2'({$random(seed)} % 4));
         hold = ($random(seed) & 1) != 0;
         if ($random(seed) & 1) begin
            run_access(1'b0, 1'b1, a, 16'($random(seed)), hold);
         end else begin
            run_access(1'b1, 1'b0, a, 16'h0, hold);
         end
      end

      $display("** PASS **");
      $finish;
   end

endmodule

// File: src.f
cache_pkg.sv
mem_pkg.sv
cache_way_if.sv
cache_way.sv
four_bank_mem.sv
mem_system.sv
tb_mem_system.sv

// File: Makefile
TOP = tb_mem_system

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module mem_system

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
